//--- axi2apb.f
rtl/axi_pkg.sv
rtl/apb_pkg.sv
rtl/chan_fifo.sv
rtl/axi_req_side.sv
rtl/apb_xfer_ctrl.sv
rtl/apb_slave_decode.sv
rtl/axi2apb_bridge.sv
dv/tb_clk_gen.sv
dv/axi2apb_props.sv
dv/tb_axi2apb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi2apb -f axi2apb.f -o tb_axi2apb_sim
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

./obj_dir/tb_axi2apb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0

//--- dv/tb_axi2apb.sv
/*
 * Testbench for the AXI4 to APB bridge
 *   Stimulus table applied in a loop, AXI master driver
 *   APB slave memories with wait states, reference memory
 *   Access monitor, response checks and watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module tb_axi2apb;

  import axi_pkg::*;

  localparam int NUM_SLAVES = 4;
  localparam int ADDR_W     = 12;
  localparam int DEPTH      = 2;
  localparam int WORDS      = 1 << (ADDR_W - 2);

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_BOTH} op_e;

  typedef struct {
    op_e         op;
    int          slave;
    logic [11:0] offset;
    logic [31:0] data;
    logic [3:0]  id;
    int          pwait;
    int          rdelay;
    bit          early;    // AW goes alone, W follows later
  } row_t;

  logic ACLK;
  logic ARESETn;
  axi_aw_t aw_i;
  logic aw_valid_i, aw_ready_o;
  logic [31:0] w_data_i;
  logic w_valid_i, w_ready_o;
  axi_ar_t ar_i;
  logic ar_valid_i, ar_ready_o;
  axi_r_t r_o;
  logic r_valid_o, r_last_o, r_ready_i;
  axi_b_t b_o;
  logic b_valid_o, b_ready_i;
  logic [NUM_SLAVES-1:0] PSEL_o;
  logic PENABLE_o, PWRITE_o;
  logic [ADDR_W-1:0] PADDR_o;
  logic [31:0] PWDATA_o;
  logic [NUM_SLAVES-1:0][31:0] PRDATA_i;
  logic [NUM_SLAVES-1:0] PREADY_i;

  row_t        rows[$];
  logic [31:0] slave_mem [NUM_SLAVES][WORDS];
  logic [31:0] ref_mem [NUM_SLAVES][WORDS];
  integer      seed = 15673;
  int          cur_wait, wait_cnt, acc_count;
  int          exp_rd_slave, exp_wr_slave;
  bit          table_loaded, expect_no_access, hold_resp;
  bit          exp_rd_ok, exp_wr_ok, first_seen, first_write;
  logic [31:0] exp_rd_addr, exp_wr_addr, exp_wdata;
  logic        prev_en, prev_rdy, prev_write;
  logic [ADDR_W-1:0] prev_addr;
  logic [31:0] prev_wdata;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) i_clk_gen (
    .ACLK_o    (ACLK),
    .ARESETn_o (ARESETn)
  );

  axi2apb_bridge #(
    .BUFFER_DEPTH   (DEPTH),
    .APB_NUM_SLAVES (NUM_SLAVES),
    .APB_ADDR_WIDTH (ADDR_W)
  ) i_dut (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .aw_i(aw_i), .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o),
    .w_data_i(w_data_i), .w_valid_i(w_valid_i), .w_ready_o(w_ready_o),
    .ar_i(ar_i), .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o),
    .r_o(r_o), .r_valid_o(r_valid_o), .r_last_o(r_last_o), .r_ready_i(r_ready_i),
    .b_o(b_o), .b_valid_o(b_valid_o), .b_ready_i(b_ready_i),
    .PSEL_o(PSEL_o), .PENABLE_o(PENABLE_o), .PWRITE_o(PWRITE_o),
    .PADDR_o(PADDR_o), .PWDATA_o(PWDATA_o), .PRDATA_i(PRDATA_i), .PREADY_i(PREADY_i)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "mismatch");
    end
  endtask

  // Initial content, a function of slave and word address
  function automatic logic [31:0] fill_word(int s, int w);
    return 32'h5A00_0000 ^ (s << 20) ^ (w * 32'h0001_0013);
  endfunction

  function automatic logic [31:0] make_addr(int s, logic [11:0] off);
    return 32'h4000_0000 | (s << ADDR_W) | off;
  endfunction

  function automatic void add_row(op_e op, int s, logic [11:0] off, logic [31:0] d,
                                  logic [3:0] id, int pw, int rd, bit early);
    row_t r;
    r = '{op: op, slave: s, offset: off, data: d, id: id, pwait: pw, rdelay: rd,
          early: early};
    rows.push_back(r);
  endfunction

  // ----------------------------------------------------------------------
  // APB slave model
  // ----------------------------------------------------------------------
  always_comb
  begin
    for (int s = 0; s < NUM_SLAVES; s++)
    begin
      PRDATA_i[s] = slave_mem[s][PADDR_o[ADDR_W-1:2]];
      PREADY_i[s] = PSEL_o[s] && PENABLE_o && (wait_cnt >= cur_wait);
    end
  end

  always @(posedge ACLK)
  begin
    if (PENABLE_o && !(|(PSEL_o & PREADY_i)))
      wait_cnt <= wait_cnt + 1;
    else
      wait_cnt <= 0;
    if (PENABLE_o && (|(PSEL_o & PREADY_i)))
    begin
      acc_count = acc_count + 1;
      if (PWRITE_o)
      begin
        for (int s = 0; s < NUM_SLAVES; s++)
          if (PSEL_o[s])
            slave_mem[s][PADDR_o[ADDR_W-1:2]] <= PWDATA_o;
        exp_wr_ok = 1'b0;        // A second write would be unexpected
      end
      else
        exp_rd_ok = 1'b0;
    end
  end

  // Access monitor, sampled mid-cycle
  always @(negedge ACLK)
  begin
    if (ARESETn)
    begin
      if (expect_no_access || hold_resp)
        check_value("PENABLE while no access allowed", PENABLE_o, 0);
      if (PENABLE_o)
      begin
        if (!first_seen)
        begin
          first_seen  = 1'b1;
          first_write = PWRITE_o;
        end
        if (PWRITE_o)
        begin
          check_value("write access expected", exp_wr_ok, 1);
          check_value("PSEL on write", PSEL_o, 1 << exp_wr_slave);
          check_value("PADDR on write", PADDR_o, exp_wr_addr[ADDR_W-1:0]);
          check_value("PWDATA", PWDATA_o, exp_wdata);
        end
        else
        begin
          check_value("read access expected", exp_rd_ok, 1);
          check_value("PSEL on read", PSEL_o, 1 << exp_rd_slave);
          check_value("PADDR on read", PADDR_o, exp_rd_addr[ADDR_W-1:0]);
        end
      end
      // A wait state keeps the access open and unchanged
      if (prev_en && !prev_rdy)
      begin
        check_value("PENABLE held in wait", PENABLE_o, 1);
        check_value("PADDR stable in wait", PADDR_o, prev_addr);
        check_value("PWDATA stable in wait", PWDATA_o, prev_wdata);
        check_value("PWRITE stable in wait", PWRITE_o, prev_write);
      end
      prev_en    = PENABLE_o;
      prev_rdy   = |(PSEL_o & PREADY_i);
      prev_addr  = PADDR_o;
      prev_wdata = PWDATA_o;
      prev_write = PWRITE_o;
    end
  end

  // ----------------------------------------------------------------------
  // AXI master driver
  // ----------------------------------------------------------------------
  task automatic send_requests();
    bit aw_hs, w_hs, ar_hs;
    while (aw_valid_i || w_valid_i || ar_valid_i)
    begin
      @(negedge ACLK);
      aw_hs = aw_valid_i && aw_ready_o;
      w_hs  = w_valid_i && w_ready_o;
      ar_hs = ar_valid_i && ar_ready_o;
      @(posedge ACLK);
      #1;
      if (aw_hs)
        aw_valid_i = 1'b0;
      if (w_hs)
        w_valid_i = 1'b0;
      if (ar_hs)
        ar_valid_i = 1'b0;
    end
  endtask

  task automatic collect_r(logic [3:0] id, logic [31:0] data, int delay);
    do @(negedge ACLK); while (!r_valid_o);
    hold_resp = 1'b1;
    for (int i = 0; i <= delay; i++)
    begin
      if (i > 0)
        @(negedge ACLK);
      check_value("RVALID held", r_valid_o, 1);
      check_value("RID", r_o.id, id);
      check_value("RDATA", r_o.data, data);
      check_value("RRESP", r_o.resp, OKAY);
      check_value("RLAST", r_last_o, 1);
    end
    @(posedge ACLK);
    #1 r_ready_i = 1'b1;
    @(negedge ACLK);
    check_value("RVALID at accept", r_valid_o, 1);
    check_value("RID at accept", r_o.id, id);
    check_value("RDATA at accept", r_o.data, data);
    @(posedge ACLK);
    #1 r_ready_i = 1'b0;
    hold_resp = 1'b0;
  endtask

  task automatic collect_b(logic [3:0] id, int delay);
    do @(negedge ACLK); while (!b_valid_o);
    hold_resp = 1'b1;
    for (int i = 0; i <= delay; i++)
    begin
      if (i > 0)
        @(negedge ACLK);
      check_value("BVALID held", b_valid_o, 1);
      check_value("BID", b_o.id, id);
      check_value("BRESP", b_o.resp, OKAY);
    end
    @(posedge ACLK);
    #1 b_ready_i = 1'b1;
    @(negedge ACLK);
    check_value("BVALID at accept", b_valid_o, 1);
    check_value("BID at accept", b_o.id, id);
    @(posedge ACLK);
    #1 b_ready_i = 1'b0;
    hold_resp = 1'b0;
  endtask

  task automatic run_row(row_t r);
    logic [31:0] addr;
    logic [31:0] waddr;
    int          nacc;
    addr       = make_addr(r.slave, r.offset);
    waddr      = (r.op == OP_BOTH) ? addr + 4 : addr;
    cur_wait   = r.pwait + ({$random(seed)} % 3);
    acc_count  = 0;
    first_seen = 1'b0;
    nacc       = (r.op == OP_BOTH) ? 2 : 1;
    if (r.op != OP_WR)
    begin
      exp_rd_addr  = addr;
      exp_rd_slave = r.slave;
      exp_rd_ok    = 1'b1;
      ar_i         = '{id: r.id, addr: addr};
      ar_valid_i   = 1'b1;
    end
    if (r.op != OP_RD)
    begin
      exp_wr_addr  = waddr;
      exp_wr_slave = r.slave;
      exp_wdata    = r.data;
      exp_wr_ok    = 1'b1;
      aw_i         = '{id: r.id + 4'd1, addr: waddr};
      aw_valid_i   = 1'b1;
      w_data_i     = r.data;
      w_valid_i    = !r.early;
    end
    send_requests();
    if (r.early)
    begin
      expect_no_access = 1'b1;   // AW waits in its FIFO without data
      repeat (4) @(posedge ACLK);
      #1 expect_no_access = 1'b0;
      w_valid_i = 1'b1;
      send_requests();
    end
    if (r.op != OP_WR)
      collect_r(r.id, ref_mem[r.slave][addr[ADDR_W-1:2]], r.rdelay);
    if (r.op != OP_RD)
    begin
      collect_b(r.id + 4'd1, r.rdelay);
      ref_mem[r.slave][waddr[ADDR_W-1:2]] = r.data;
    end
    if (r.op == OP_BOTH)
      check_value("first access of a read and write pair is a read", first_write, 0);
    check_value("APB accesses in row", acc_count, nacc);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------
  initial
  begin
    aw_i = '0;
    aw_valid_i = 1'b0;
    w_data_i = '0;
    w_valid_i = 1'b0;
    ar_i = '0;
    ar_valid_i = 1'b0;
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    wait_cnt <= 0;
    for (int s = 0; s < NUM_SLAVES; s++)
      for (int w = 0; w < WORDS; w++)
      begin
        slave_mem[s][w] <= fill_word(s, w);
        ref_mem[s][w]   = fill_word(s, w);
      end
    //      op       slave offset   data          id   wait delay early
    add_row(OP_WR,   0, 12'h010, 32'hDEADBEEF, 4'h1, 0, 0, 0);
    add_row(OP_RD,   0, 12'h010, 32'h0,        4'h2, 0, 0, 0);
    add_row(OP_WR,   2, 12'h7FC, 32'h12345678, 4'h3, 3, 2, 0);
    add_row(OP_RD,   2, 12'h7FC, 32'h0,        4'h4, 2, 3, 0);
    add_row(OP_WR,   1, 12'h100, 32'hCAFEF00D, 4'h5, 1, 0, 1);
    add_row(OP_RD,   1, 12'h100, 32'h0,        4'h6, 0, 1, 0);
    add_row(OP_BOTH, 3, 12'h040, 32'h0BADC0DE, 4'h7, 1, 1, 0);
    add_row(OP_RD,   3, 12'h044, 32'h0,        4'h9, 1, 0, 0);
    add_row(OP_RD,   1, 12'hFFC, 32'h0,        4'hA, 4, 1, 0);
    add_row(OP_WR,   3, 12'hFFC, 32'hA5A55A5A, 4'hB, 2, 3, 1);
    add_row(OP_RD,   3, 12'hFFC, 32'h0,        4'hC, 0, 0, 0);
    table_loaded = 1'b1;

    @(posedge ARESETn);
    @(negedge ACLK);
    check_value("PENABLE after reset", PENABLE_o, 0);
    check_value("PSEL after reset", PSEL_o, 0);
    check_value("RVALID after reset", r_valid_o, 0);
    check_value("BVALID after reset", b_valid_o, 0);
    check_value("request readies after reset", {aw_ready_o, w_ready_o, ar_ready_o}, 3'b111);
    @(posedge ACLK);
    #1;
    foreach (rows[i])
      run_row(rows[i]);
    $display("All checks passed");
    $finish;
  end

  initial
  begin
    int max_wait;
    wait (table_loaded);
    max_wait = 0;
    foreach (rows[i])
      if (2 * (rows[i].pwait + 2) + rows[i].rdelay + 5 > max_wait)
        max_wait = 2 * (rows[i].pwait + 2) + rows[i].rdelay + 5;
    #((rows.size() + 1) * (max_wait + 10) * 40);
    $display("Timeout: the run did not finish in the expected time");
    $display("Checks failed");
    $fatal(1, "watchdog");
  end

endmodule

`default_nettype wire

//--- dv/axi2apb_props.sv
/*
 * Concurrent assertions for the bridge ports
 *   PSEL one-hot with PENABLE, APB stable during wait states
 *   R and B held stable until accepted
 */

`timescale 1ns/1ps
`default_nettype none

module axi2apb_props #(
  parameter int NUM_SLAVES = 4,
  parameter int ADDR_W     = 12
) (
  input wire logic                  ACLK,
  input wire logic                  ARESETn,
  input wire logic [NUM_SLAVES-1:0] psel_i,
  input wire logic                  penable_i,
  input wire logic [ADDR_W-1:0]     paddr_i,
  input wire logic [31:0]           pwdata_i,
  input wire logic [NUM_SLAVES-1:0] pready_i,
  input wire axi_pkg::axi_r_t       r_i,
  input wire logic                  r_valid_i,
  input wire logic                  r_ready_i,
  input wire axi_pkg::axi_b_t       b_i,
  input wire logic                  b_valid_i,
  input wire logic                  b_ready_i
);

  logic sel_ready;

  assign sel_ready = |(psel_i & pready_i);

  psel_onehot: assert property (@(posedge ACLK) disable iff (!ARESETn)
    $onehot0(psel_i) && (penable_i == (psel_i != '0)))
    else $error("PSEL not one-hot with PENABLE");

  apb_wait_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    penable_i && !sel_ready |=> penable_i && $stable(paddr_i) && $stable(pwdata_i))
    else $error("APB access changed during wait state");

  r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R response dropped or changed before acceptance");

  b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else $error("B response dropped or changed before acceptance");

endmodule

bind axi2apb_bridge axi2apb_props #(
  .NUM_SLAVES (APB_NUM_SLAVES),
  .ADDR_W     (APB_ADDR_WIDTH)
) i_props (
  .ACLK      (ACLK),
  .ARESETn   (ARESETn),
  .psel_i    (PSEL_o),
  .penable_i (PENABLE_o),
  .paddr_i   (PADDR_o),
  .pwdata_i  (PWDATA_o),
  .pready_i  (PREADY_i),
  .r_i       (r_o),
  .r_valid_i (r_valid_o),
  .r_ready_i (r_ready_i),
  .b_i       (b_o),
  .b_valid_i (b_valid_o),
  .b_ready_i (b_ready_i)
);

`default_nettype wire

//--- dv/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 *   ACLK with a fixed period
 *   ARESETn held low for a number of cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic ACLK_o,
  output logic ARESETn_o
);

  initial
  begin
    ACLK_o = 1'b0;
    forever #(PERIOD_NS / 2) ACLK_o = ~ACLK_o;
  end

  initial
  begin
    ARESETn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge ACLK_o);
    #1 ARESETn_o = 1'b1;             // Released just after an edge
  end

endmodule

`default_nettype wire

//--- rtl/axi2apb_bridge.sv
/*
 * axi2apb_bridge
 *   AXI4 target port to multi-slave APB bus, single beat only
 *   Request buffers, transfer FSM and slave decode
 */

`timescale 1ns/1ps
`default_nettype none

module axi2apb_bridge #(
  parameter int BUFFER_DEPTH   = 2,
  parameter int APB_NUM_SLAVES = 4,
  parameter int APB_ADDR_WIDTH = 12
) (
  input  wire logic                                                  ACLK,
  input  wire logic                                                  ARESETn,
  // AXI target port
  input  wire axi_pkg::axi_aw_t                                      aw_i,
  input  wire logic                                                  aw_valid_i,
  output logic                                                       aw_ready_o,
  input  wire logic [axi_pkg::AXI_DATA_W-1:0]                        w_data_i,
  input  wire logic                                                  w_valid_i,
  output logic                                                       w_ready_o,
  input  wire axi_pkg::axi_ar_t                                      ar_i,
  input  wire logic                                                  ar_valid_i,
  output logic                                                       ar_ready_o,
  output axi_pkg::axi_r_t                                            r_o,
  output logic                                                       r_valid_o,
  output logic                                                       r_last_o,
  input  wire logic                                                  r_ready_i,
  output axi_pkg::axi_b_t                                            b_o,
  output logic                                                       b_valid_o,
  input  wire logic                                                  b_ready_i,
  // APB master port
  output logic [APB_NUM_SLAVES-1:0]                                  PSEL_o,
  output logic                                                       PENABLE_o,
  output logic                                                       PWRITE_o,
  output logic [APB_ADDR_WIDTH-1:0]                                  PADDR_o,
  output logic [apb_pkg::APB_DATA_W-1:0]                             PWDATA_o,
  input  wire logic [APB_NUM_SLAVES-1:0][apb_pkg::APB_DATA_W-1:0]    PRDATA_i,
  input  wire logic [APB_NUM_SLAVES-1:0]                             PREADY_i
);

  import axi_pkg::*;
  import apb_pkg::*;

  axi_wreq_t             wreq;
  logic                  wreq_valid;
  logic                  wreq_pop;
  axi_ar_t               ar_head;
  logic                  ar_head_valid;
  logic                  ar_pop;
  apb_req_t              apb_req;
  logic                  sel_ready;
  logic [APB_DATA_W-1:0] sel_rdata;

  axi_req_side #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_req_side (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .aw_i         (aw_i),
    .aw_valid_i   (aw_valid_i),
    .aw_ready_o   (aw_ready_o),
    .w_data_i     (w_data_i),
    .w_valid_i    (w_valid_i),
    .w_ready_o    (w_ready_o),
    .ar_i         (ar_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .wreq_o       (wreq),
    .wreq_valid_o (wreq_valid),
    .wreq_pop_i   (wreq_pop),
    .ar_o         (ar_head),
    .ar_valid_o   (ar_head_valid),
    .ar_pop_i     (ar_pop)
  );

  apb_xfer_ctrl i_xfer_ctrl (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .wreq_i       (wreq),
    .wreq_valid_i (wreq_valid),
    .wreq_pop_o   (wreq_pop),
    .ar_i         (ar_head),
    .ar_valid_i   (ar_head_valid),
    .ar_pop_o     (ar_pop),
    .apb_req_o    (apb_req),
    .sel_ready_i  (sel_ready),
    .sel_rdata_i  (sel_rdata),
    .r_o          (r_o),
    .r_valid_o    (r_valid_o),
    .r_last_o     (r_last_o),
    .r_ready_i    (r_ready_i),
    .b_o          (b_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i)
  );

  apb_slave_decode #(
    .APB_NUM_SLAVES (APB_NUM_SLAVES),
    .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
  ) i_slave_decode (
    .apb_req_i   (apb_req),
    .PSEL_o      (PSEL_o),
    .PENABLE_o   (PENABLE_o),
    .PWRITE_o    (PWRITE_o),
    .PADDR_o     (PADDR_o),
    .PWDATA_o    (PWDATA_o),
    .PRDATA_i    (PRDATA_i),
    .PREADY_i    (PREADY_i),
    .sel_ready_o (sel_ready),
    .sel_rdata_o (sel_rdata)
  );

endmodule

`default_nettype wire

//--- rtl/apb_slave_decode.sv
/*
 * apb_slave_decode
 *   Slave index from the bits above the APB address field
 *   One-hot PSEL, PREADY and PRDATA selection
 */

`timescale 1ns/1ps
`default_nettype none

module apb_slave_decode #(
  parameter int APB_NUM_SLAVES = 4,
  parameter int APB_ADDR_WIDTH = 12
) (
  input  wire apb_pkg::apb_req_t                                     apb_req_i,
  output logic [APB_NUM_SLAVES-1:0]                                  PSEL_o,
  output logic                                                       PENABLE_o,
  output logic                                                       PWRITE_o,
  output logic [APB_ADDR_WIDTH-1:0]                                  PADDR_o,
  output logic [apb_pkg::APB_DATA_W-1:0]                             PWDATA_o,
  input  wire logic [APB_NUM_SLAVES-1:0][apb_pkg::APB_DATA_W-1:0]    PRDATA_i,
  input  wire logic [APB_NUM_SLAVES-1:0]                             PREADY_i,
  output logic                                                       sel_ready_o,
  output logic [apb_pkg::APB_DATA_W-1:0]                             sel_rdata_o
);

  localparam int IDX_W = $clog2(APB_NUM_SLAVES);

  logic [IDX_W-1:0] slave_idx;

  assign slave_idx = apb_req_i.addr[APB_ADDR_WIDTH +: IDX_W];

  always_comb
  begin
    PSEL_o = '0;
    if (apb_req_i.enable)
      PSEL_o[slave_idx] = 1'b1;
  end

  // No setup phase, PENABLE rises with PSEL
  assign PENABLE_o = apb_req_i.enable;
  assign PWRITE_o  = apb_req_i.write;
  assign PADDR_o   = apb_req_i.addr[APB_ADDR_WIDTH-1:0];
  assign PWDATA_o  = apb_req_i.wdata;

  assign sel_ready_o = PREADY_i[slave_idx];
  assign sel_rdata_o = PRDATA_i[slave_idx];

endmodule

`default_nettype wire

//--- rtl/apb_xfer_ctrl.sv
/*
 * apb_xfer_ctrl
 *   FSM running one APB access at a time, reads first
 *   Read data capture on PREADY
 *   R and B response generation, held until accepted
 */

`timescale 1ns/1ps
`default_nettype none

module apb_xfer_ctrl (
  input  wire logic                             ACLK,
  input  wire logic                             ARESETn,
  input  wire axi_pkg::axi_wreq_t               wreq_i,
  input  wire logic                             wreq_valid_i,
  output logic                                  wreq_pop_o,
  input  wire axi_pkg::axi_ar_t                 ar_i,
  input  wire logic                             ar_valid_i,
  output logic                                  ar_pop_o,
  output apb_pkg::apb_req_t                     apb_req_o,
  input  wire logic                             sel_ready_i,
  input  wire logic [apb_pkg::APB_DATA_W-1:0]   sel_rdata_i,
  output axi_pkg::axi_r_t                       r_o,
  output logic                                  r_valid_o,
  output logic                                  r_last_o,
  input  wire logic                             r_ready_i,
  output axi_pkg::axi_b_t                       b_o,
  output logic                                  b_valid_o,
  input  wire logic                             b_ready_i
);

  import axi_pkg::*;
  import apb_pkg::*;

  xfer_state_e           state_q;
  xfer_state_e           state_d;
  logic                  rd_access;  // Read on the APB bus this cycle
  logic                  wr_access;  // Write on the APB bus this cycle
  logic [APB_DATA_W-1:0] rdata_q;

  // ----------------------------------------------------------------------
  // Next state and access selection
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_d   = state_q;
    rd_access = 1'b0;
    wr_access = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (ar_valid_i)
        begin
          // Read wins over a pending write
          rd_access = 1'b1;
          state_d   = sel_ready_i ? SEND_R : WAIT_R_READY;
        end
        else if (wreq_valid_i)
        begin
          wr_access = 1'b1;
          state_d   = sel_ready_i ? SEND_B : WAIT_W_READY;
        end
      end
      WAIT_R_READY:
      begin
        rd_access = 1'b1;
        if (sel_ready_i)
          state_d = SEND_R;
      end
      WAIT_W_READY:
      begin
        wr_access = 1'b1;
        if (sel_ready_i)
          state_d = SEND_B;
      end
      SEND_R:
      begin
        if (r_ready_i)
          state_d = IDLE;
      end
      SEND_B:
      begin
        if (b_ready_i)
          state_d = IDLE;
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge ACLK)
  begin
    if (rd_access && sel_ready_i)
      rdata_q <= sel_rdata_i; // Slave data valid with PREADY
  end

  // ----------------------------------------------------------------------
  // APB request and AXI responses
  // ----------------------------------------------------------------------
  always_comb
  begin
    apb_req_o.enable = rd_access | wr_access;
    apb_req_o.write  = wr_access;
    apb_req_o.addr   = rd_access ? ar_i.addr : wreq_i.addr;
    apb_req_o.wdata  = wreq_i.data;
  end

  // Heads stay in the FIFOs until the response is taken
  assign r_valid_o = (state_q == SEND_R);
  assign r_last_o  = r_valid_o;          // Single beat only
  assign r_o       = '{id: ar_i.id, data: rdata_q, resp: OKAY};
  assign ar_pop_o  = r_valid_o & r_ready_i;

  assign b_valid_o  = (state_q == SEND_B);
  assign b_o        = '{id: wreq_i.id, resp: OKAY};
  assign wreq_pop_o = b_valid_o & b_ready_i;

endmodule

`default_nettype wire

//--- rtl/axi_req_side.sv
/*
 * axi_req_side
 *   AW, W and AR channel buffers
 *   Pairing of the AW head with the W head into one write request
 */

`timescale 1ns/1ps
`default_nettype none

module axi_req_side #(
  parameter int BUFFER_DEPTH = 2
) (
  input  wire logic                             ACLK,
  input  wire logic                             ARESETn,
  input  wire axi_pkg::axi_aw_t                 aw_i,
  input  wire logic                             aw_valid_i,
  output logic                                  aw_ready_o,
  input  wire logic [axi_pkg::AXI_DATA_W-1:0]   w_data_i,
  input  wire logic                             w_valid_i,
  output logic                                  w_ready_o,
  input  wire axi_pkg::axi_ar_t                 ar_i,
  input  wire logic                             ar_valid_i,
  output logic                                  ar_ready_o,
  output axi_pkg::axi_wreq_t                    wreq_o,
  output logic                                  wreq_valid_o,
  input  wire logic                             wreq_pop_i,
  output axi_pkg::axi_ar_t                      ar_o,
  output logic                                  ar_valid_o,
  input  wire logic                             ar_pop_i
);

  import axi_pkg::*;

  axi_aw_t               aw_head;
  logic                  aw_head_valid;
  logic [AXI_DATA_W-1:0] w_head;
  logic                  w_head_valid;

  chan_fifo #(.WIDTH($bits(axi_aw_t)), .DEPTH(BUFFER_DEPTH)) i_aw_fifo (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .push_valid_i (aw_valid_i),
    .push_data_i  (aw_i),
    .push_ready_o (aw_ready_o),
    .pop_valid_o  (aw_head_valid),
    .pop_data_o   (aw_head),
    .pop_ready_i  (wreq_pop_i)   // Popped together with W
  );

  chan_fifo #(.WIDTH(AXI_DATA_W), .DEPTH(BUFFER_DEPTH)) i_w_fifo (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .push_valid_i (w_valid_i),
    .push_data_i  (w_data_i),
    .push_ready_o (w_ready_o),
    .pop_valid_o  (w_head_valid),
    .pop_data_o   (w_head),
    .pop_ready_i  (wreq_pop_i)
  );

  chan_fifo #(.WIDTH($bits(axi_ar_t)), .DEPTH(BUFFER_DEPTH)) i_ar_fifo (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .push_valid_i (ar_valid_i),
    .push_data_i  (ar_i),
    .push_ready_o (ar_ready_o),
    .pop_valid_o  (ar_valid_o),
    .pop_data_o   (ar_o),
    .pop_ready_i  (ar_pop_i)
  );

  // A write exists only once both halves are present
  assign wreq_valid_o = aw_head_valid & w_head_valid;
  assign wreq_o       = '{id: aw_head.id, addr: aw_head.addr, data: w_head};

endmodule

`default_nettype wire

//--- rtl/chan_fifo.sv
/*
 * chan_fifo
 *   Circular buffer with valid/ready on both sides
 *   Push and pop may happen in the same cycle
 */

`timescale 1ns/1ps
`default_nettype none

module chan_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 2
) (
  input  wire logic             ACLK,
  input  wire logic             ARESETn,
  input  wire logic             push_valid_i,
  input  wire logic [WIDTH-1:0] push_data_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output logic [WIDTH-1:0]      pop_data_o,
  input  wire logic             pop_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push_en;
  logic             pop_en;

  assign push_ready_o = (cnt_q != CNT_W'(DEPTH)); // Low only when full
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push_en = push_valid_i & push_ready_o;
  assign pop_en  = pop_valid_o & pop_ready_i;

  always_ff @(posedge ACLK)
  begin
    if (push_en)
    begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_en)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_en)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      // Count holds when both happen
      if (push_en && !pop_en)
        cnt_q <= cnt_q + 1'b1;
      else if (!push_en && pop_en)
        cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/apb_pkg.sv
/*
 * APB side definitions
 *   data width
 *   access request from the transfer controller
 *   transfer controller state enum
 */

`default_nettype none

package apb_pkg;

  localparam int APB_DATA_W = 32;

  typedef struct packed {
    logic                              enable; // Access in progress
    logic                              write;
    logic [axi_pkg::AXI_ADDR_W-1:0]    addr;   // Full AXI address, decoded later
    logic [APB_DATA_W-1:0]             wdata;
  } apb_req_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_R_READY,
    WAIT_W_READY,
    SEND_R,
    SEND_B
  } xfer_state_e;

endpackage

`default_nettype wire

//--- rtl/axi_pkg.sv
/*
 * AXI4 definitions for the bridge target port
 *   widths of ID, address and data
 *   response code enum
 *   AW, AR, R and B channel payload structs
 *   paired write request (address with data)
 */

`default_nettype none

package axi_pkg;

  localparam int AXI_ID_W   = 4;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // ----------------------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
  } axi_r_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  // AW head joined with W head
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_DATA_W-1:0] data;
  } axi_wreq_t;

endpackage

`default_nettype wire
